// File: tb.f
design/sd_spi_pkg.sv
design/sd_wait_timer.sv
design/sd_init_seq.sv
design/sd_cmd_tx.sv
design/sd_resp_rx.sv
design/sd_init_top.sv
tb/sd_card_model.sv
tb/tb_sd_init.sv

// File: tb/tb_sd_init.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sd_init;

    localparam int POWER_ON_NUM  = 20;
    localparam int OVER_TIME_NUM = 200;
    localparam int SCENARIOS     = 5;
    localparam int RETRY_MAX     = 8;  // restarts plus busy rounds, worst scenario
    localparam int WATCHDOG_CYCLES =
        2 * SCENARIOS * (RETRY_MAX + 1) * (POWER_ON_NUM + 4 * (OVER_TIME_NUM + 60));

    // spi-mode frames as the card expects them: index, argument, crc
    localparam logic [47:0] GO_IDLE  = 48'h40_0000_0000_95;
    localparam logic [47:0] SEND_IF  = 48'h48_0000_01aa_87;
    localparam logic [47:0] APP_CMD  = 48'h77_0000_0000_ff;
    localparam logic [47:0] SEND_OPC = 48'h69_4000_0000_ff;

    logic        div_clk;
    logic        rst_n;
    logic        sd_clk;
    logic        sd_cs;
    logic        sd_mosi;
    logic        sd_miso;
    logic        init_done;
    logic [7:0]  drop_cmd0;
    logic        bad_volt_once;
    logic [7:0]  busy_count;
    logic        frame_valid;
    logic [47:0] frame_word;
    int          frame_idx;
    int          fail_count;
    int          rand_busy;
    integer      seed;

    sd_init_top #(
        .POWER_ON_NUM  (POWER_ON_NUM),
        .OVER_TIME_NUM (OVER_TIME_NUM)
    ) UUT (
        .div_clk   (div_clk),
        .rst_n     (rst_n),
        .sd_miso   (sd_miso),
        .sd_clk    (sd_clk),
        .sd_cs     (sd_cs),
        .sd_mosi   (sd_mosi),
        .init_done (init_done)
    );

    sd_card_model u_card (
        .rst_n         (rst_n),
        .sd_clk        (sd_clk),
        .sd_cs         (sd_cs),
        .sd_mosi       (sd_mosi),
        .drop_cmd0     (drop_cmd0),
        .bad_volt_once (bad_volt_once),
        .busy_count    (busy_count),
        .sd_miso       (sd_miso),
        .frame_valid   (frame_valid),
        .frame_word    (frame_word)
    );

    initial begin
        div_clk = 1'b0;
        forever #2 div_clk = ~div_clk;
    end

    task automatic check_value(input string what, input logic [47:0] got,
                               input logic [47:0] exp);
        if (got !== exp) begin
            fail_count = fail_count + 1;
            $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // ********************
    // reference sequence
    // ********************
    // ignored cmd0s, cmd0/cmd8 pair (twice after a bad voltage), then cmd55/acmd41 rounds
    function automatic logic [47:0] expected_frame(input int drop, input int bad,
                                                   input int busy, input int idx);
        int k;
        k = idx;
        if (k < drop)
            return GO_IDLE;
        k = k - drop;
        if (k < 2 + 2 * bad)
            return (k % 2 == 0) ? GO_IDLE : SEND_IF;
        k = k - 2 - 2 * bad;
        if (k < 2 * (busy + 1))
            return (k % 2 == 0) ? APP_CMD : SEND_OPC;
        return '0;  // nothing more is expected
    endfunction

    // every frame the card logs is compared against the reference
    always @(posedge div_clk) begin
        if (rst_n === 1'b1 && frame_valid === 1'b1) begin
            check_value("init_done low while frames are sent", init_done, 1'b0);
            check_value($sformatf("frame %0d", frame_idx), frame_word,
                        expected_frame(drop_cmd0, bad_volt_once, busy_count, frame_idx));
            frame_idx = frame_idx + 1;
        end
    end

    // sd_clk is div_clk inverted, looked at away from the edges
    always @(div_clk) begin
        #1;
        check_value("sd_clk not the inverse of div_clk", sd_clk, !div_clk);
    end

    task automatic run_scenario(input int drop, input int bad, input int busy);
        int   exp_count;
        int   last_idx;
        logic reply_low;
        exp_count = drop + 2 + 2 * bad + 2 * (busy + 1);
        last_idx  = -1;
        reply_low = 1'b0;
        @(posedge div_clk);
        #1;
        rst_n         = 1'b0;
        drop_cmd0     = 8'(drop);
        bad_volt_once = (bad != 0);
        busy_count    = 8'(busy);
        frame_idx     = 0;
        repeat (4) begin
            @(negedge div_clk);
            check_value("sd_cs in reset", sd_cs, 1'b1);
            check_value("sd_mosi in reset", sd_mosi, 1'b1);
        end
        @(posedge div_clk);
        #1;
        rst_n = 1'b1;
        repeat (POWER_ON_NUM) begin  // power wait, bus stays idle
            @(negedge div_clk);
            check_value("sd_cs in power wait", sd_cs, 1'b1);
            check_value("sd_mosi in power wait", sd_mosi, 1'b1);
        end
        do begin
            @(negedge div_clk);
            if (frame_idx != last_idx) begin
                last_idx  = frame_idx;  // new frame, its reply still to come
                reply_low = 1'b0;
            end else if (sd_miso === 1'b0) begin
                reply_low = 1'b1;
            end
        end while (init_done !== 1'b1);
        check_value("frame count at init_done", frame_idx, exp_count);
        check_value("last acmd41 answered before init_done", reply_low, 1'b1);
        check_value("sd_cs after init_done", sd_cs, 1'b1);
        repeat (20) begin
            @(negedge div_clk);
            check_value("init_done held", init_done, 1'b1);
            check_value("sd_mosi idle after init", sd_mosi, 1'b1);
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        drop_cmd0     = '0;
        bad_volt_once = 1'b0;
        busy_count    = '0;
        frame_idx     = 0;
        fail_count    = 0;
        seed          = 32'h53a8a1eb;
        rand_busy     = $unsigned($random(seed)) % 6 + 1;
        run_scenario(0, 0, 0);          // plain card
        run_scenario(2, 0, 0);          // two lost cmd0 frames
        run_scenario(0, 1, 0);          // voltage mismatch once
        run_scenario(0, 0, 2);
        run_scenario(0, 0, rand_busy);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // ********************
    // watchdog
    // ********************
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge div_clk);
        $display("[TIMEOUT] %0t ns: init_done never arrived within %0d cycles",
                 $time, WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: tb/sd_card_model.sv
`timescale 1ns/1ps
`default_nettype none

module sd_card_model (
    input  logic        rst_n,
    input  logic        sd_clk,
    input  logic        sd_cs,
    input  logic        sd_mosi,
    input  logic [7:0]  drop_cmd0,      // cmd0 frames left unanswered
    input  logic        bad_volt_once,  // first cmd8 reply reports no voltage match
    input  logic [7:0]  busy_count,     // acmd41 replies that still say busy
    output logic        sd_miso,
    output logic        frame_valid,
    output logic [47:0] frame_word
);
    import sd_spi_pkg::*;

    localparam logic [39:0] PAD = '1;  // idle-high bits after an r1 byte

    logic [47:0] rx_q;
    logic [5:0]  rx_cnt;
    logic        rx_busy;
    logic [7:0]  cmd0_seen;
    logic [7:0]  acmd41_seen;
    logic        volt_failed;
    logic        reply_due;
    logic [47:0] reply_word;
    logic [47:0] tx_q;
    logic [5:0]  tx_cnt;
    logic        tx_busy;

    initial begin
        sd_miso     = 1'b1;
        frame_valid = 1'b0;
        rx_busy     = 1'b0;
        tx_busy     = 1'b0;
        reply_due   = 1'b0;
    end

    // ********************
    // command intake
    // ********************
    always @(posedge sd_clk) begin : intake
        logic [47:0] f;
        f = {rx_q[46:0], sd_mosi};
        frame_valid <= 1'b0;
        reply_due   <= 1'b0;
        if (!rst_n) begin
            rx_busy     <= 1'b0;
            rx_cnt      <= '0;
            cmd0_seen   <= '0;
            acmd41_seen <= '0;
            volt_failed <= 1'b0;
        end else if (sd_cs) begin
            rx_busy <= 1'b0;  // deselect drops a partial frame
            rx_cnt  <= '0;
        end else if (rx_busy || !sd_mosi) begin
            rx_q    <= f;
            rx_busy <= 1'b1;
            rx_cnt  <= rx_cnt + 1'b1;
            if (rx_cnt == 6'd47) begin
                rx_busy     <= 1'b0;
                rx_cnt      <= '0;
                frame_valid <= 1'b1;
                frame_word  <= f;
                reply_due   <= 1'b1;
                case (f[47:40])
                    8'h40: begin
                        if (cmd0_seen < drop_cmd0) begin
                            cmd0_seen <= cmd0_seen + 1'b1;
                            reply_due <= 1'b0;  // silent, host has to time out
                        end else begin
                            reply_word <= {R1_IDLE, PAD};
                        end
                    end
                    8'h48: begin
                        // r7: version, reserved, voltage, check pattern echo
                        if (bad_volt_once && !volt_failed) begin
                            volt_failed <= 1'b1;
                            reply_word  <= {R1_IDLE, 4'h0, 16'h0, 4'b0000, f[15:8], 8'hff};
                        end else begin
                            reply_word <= {R1_IDLE, 4'h0, 16'h0, VOLT_OK, f[15:8], 8'hff};
                        end
                    end
                    8'h77:
                        reply_word <= {R1_IDLE, PAD};
                    8'h69: begin
                        acmd41_seen <= acmd41_seen + 1'b1;
                        if (acmd41_seen < busy_count)
                            reply_word <= {R1_IDLE, PAD};  // still busy
                        else
                            reply_word <= {R1_READY, PAD};
                    end
                    default:
                        reply_word <= {8'h05, PAD};  // illegal command
                endcase
            end
        end
    end

    // ********************
    // reply on sd_clk fall
    // ********************
    always @(negedge sd_clk) begin
        if (!rst_n) begin
            tx_busy <= 1'b0;
            tx_cnt  <= '0;
            sd_miso <= 1'b1;
        end else if (tx_busy) begin
            tx_cnt <= tx_cnt + 1'b1;
            if (tx_cnt < 6'd8) begin
                sd_miso <= 1'b1;  // gap before the answer
            end else begin
                sd_miso <= tx_q[47];
                tx_q    <= {tx_q[46:0], 1'b1};
                if (tx_cnt == 6'd55)
                    tx_busy <= 1'b0;
            end
        end else begin
            sd_miso <= 1'b1;
            if (reply_due) begin
                tx_busy <= 1'b1;
                tx_cnt  <= '0;
                tx_q    <= reply_word;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/sd_init_top.sv
`timescale 1ns/1ps
`default_nettype none

module sd_init_top #(
    parameter int unsigned POWER_ON_NUM  = 5000,
    parameter int unsigned OVER_TIME_NUM = 25000
) (
    input  logic div_clk,
    input  logic rst_n,
    input  logic sd_miso,
    output logic sd_clk,
    output logic sd_cs,
    output logic sd_mosi,
    output logic init_done
);
    import sd_spi_pkg::*;

    logic      pwr_wait;
    logic      resp_wait;
    logic      pwr_ok;
    logic      time_out;
    logic      cmd_start;
    logic      cmd_done;
    logic      resp_valid;
    cmd_sel_t  cmd_sel;
    sd_resp_u  resp_word;

    // card samples mosi on sd_clk rise, halfway through the div_clk cycle
    assign sd_clk = ~div_clk;

    // ********************
    // stages
    // ********************
    sd_wait_timer #(
        .POWER_ON_NUM  (POWER_ON_NUM),
        .OVER_TIME_NUM (OVER_TIME_NUM)
    ) u_timer (
        .div_clk   (div_clk),
        .rst_n     (rst_n),
        .pwr_wait  (pwr_wait),
        .resp_wait (resp_wait),
        .pwr_ok    (pwr_ok),
        .time_out  (time_out)
    );

    sd_init_seq u_seq (
        .div_clk    (div_clk),
        .rst_n      (rst_n),
        .pwr_ok     (pwr_ok),
        .time_out   (time_out),
        .cmd_done   (cmd_done),
        .resp_valid (resp_valid),
        .resp_word  (resp_word),
        .pwr_wait   (pwr_wait),
        .resp_wait  (resp_wait),
        .cmd_start  (cmd_start),
        .cmd_sel    (cmd_sel),
        .sd_cs      (sd_cs),
        .init_done  (init_done)
    );

    sd_cmd_tx u_tx (
        .div_clk   (div_clk),
        .rst_n     (rst_n),
        .cmd_start (cmd_start),
        .cmd_sel   (cmd_sel),
        .cmd_done  (cmd_done),
        .sd_mosi   (sd_mosi)
    );

    sd_resp_rx u_rx (
        .div_clk    (div_clk),
        .rst_n      (rst_n),
        .sd_miso    (sd_miso),
        .resp_valid (resp_valid),
        .resp_word  (resp_word)
    );

endmodule

`default_nettype wire

// File: design/sd_resp_rx.sv
`timescale 1ns/1ps
`default_nettype none

module sd_resp_rx (
    input  logic                 div_clk,
    input  logic                 rst_n,
    input  logic                 sd_miso,
    output logic                 resp_valid,
    output sd_spi_pkg::sd_resp_u resp_word
);
    import sd_spi_pkg::*;

    localparam logic [5:0] LAST_BIT = 6'(FRAME_W - 1);

    logic [FRAME_W-1:0] shift_q;
    logic [5:0]         bit_cnt;
    logic               busy;

    // ********************
    // capture on falling edge
    // ********************
    // falling edge of div_clk is the rising edge of sd_clk, where the card data is settled

    // payload path
    always_ff @(negedge div_clk) begin
        if (busy || !sd_miso)
            shift_q <= {shift_q[FRAME_W-2:0], sd_miso};
        if (busy && bit_cnt == LAST_BIT)
            resp_word <= {shift_q[FRAME_W-2:0], sd_miso};  // held until next reply
    end

    always_ff @(negedge div_clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            bit_cnt    <= '0;
            resp_valid <= 1'b0;
        end else if (busy) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == LAST_BIT) begin
                busy       <= 1'b0;
                bit_cnt    <= '0;
                resp_valid <= 1'b1;
            end
        end else begin
            resp_valid <= 1'b0;
            // start bit, r1 msb is always zero
            if (!sd_miso) begin
                busy    <= 1'b1;
                bit_cnt <= 6'd1;
            end
        end
    end

    // short replies just pick up idle-high padding from the card

endmodule

`default_nettype wire

// File: design/sd_cmd_tx.sv
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_tx (
    input  logic                 div_clk,
    input  logic                 rst_n,
    input  logic                 cmd_start,
    input  sd_spi_pkg::cmd_sel_t cmd_sel,
    output logic                 cmd_done,
    output logic                 sd_mosi
);
    import sd_spi_pkg::*;

    localparam logic [5:0] LAST_BIT = 6'(FRAME_W - 1);

    logic [FRAME_W-1:0] frame;
    logic [FRAME_W-1:0] shift_q;
    logic [5:0]         bit_cnt;
    logic               busy;

    always_comb begin
        case (cmd_sel)
            CMD0:    frame = CMD0_FRAME;
            CMD8:    frame = CMD8_FRAME;
            CMD55:   frame = CMD55_FRAME;
            default: frame = ACMD41_FRAME;
        endcase
    end

    // frame shift register
    always_ff @(posedge div_clk) begin
        if (cmd_start && !busy)
            shift_q <= frame;
        else if (busy)
            shift_q <= {shift_q[FRAME_W-2:0], 1'b1};  // msb first
    end

    always_ff @(posedge div_clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            bit_cnt  <= '0;
            cmd_done <= 1'b0;
            sd_mosi  <= 1'b1;
        end else if (busy) begin
            sd_mosi <= shift_q[FRAME_W-1];
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == LAST_BIT) begin
                busy     <= 1'b0;
                bit_cnt  <= '0;
                cmd_done <= 1'b1;  // high while bit 0 is on the line
            end
        end else begin
            cmd_done <= 1'b0;
            sd_mosi  <= 1'b1;  // idle high
            if (cmd_start)
                busy <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/sd_init_seq.sv
`timescale 1ns/1ps
`default_nettype none

module sd_init_seq (
    input  logic                 div_clk,
    input  logic                 rst_n,
    input  logic                 pwr_ok,
    input  logic                 time_out,
    input  logic                 cmd_done,
    input  logic                 resp_valid,
    input  sd_spi_pkg::sd_resp_u resp_word,
    output logic                 pwr_wait,
    output logic                 resp_wait,
    output logic                 cmd_start,
    output sd_spi_pkg::cmd_sel_t cmd_sel,
    output logic                 sd_cs,
    output logic                 init_done
);
    import sd_spi_pkg::*;

    logic [SEQ_ST_W-1:0] state;
    logic [SEQ_ST_W-1:0] judged_st;  // where a received response leads
    logic                launched;   // cmd_start already given in this send half

    assign pwr_wait  = (state == ST_POWER);
    assign init_done = (state == ST_DONE);
    assign resp_wait = (state == ST_CMD0_RX) || (state == ST_CMD8_RX) ||
                       (state == ST_CMD55_RX) || (state == ST_ACMD41_RX);

    // frame follows the phase
    always_comb begin
        case (state)
            ST_CMD0_TX, ST_CMD0_RX:   cmd_sel = CMD0;
            ST_CMD8_TX, ST_CMD8_RX:   cmd_sel = CMD8;
            ST_CMD55_TX, ST_CMD55_RX: cmd_sel = CMD55;
            default:                  cmd_sel = ACMD41;
        endcase
    end

    // ********************
    // response judgement
    // ********************
    always_comb begin
        case (state)
            ST_CMD0_RX:
                judged_st = (resp_word.r1.status == R1_IDLE) ? ST_CMD8_TX : ST_POWER;
            ST_CMD8_RX:
                judged_st = (resp_word.r7.volt == VOLT_OK) ? ST_CMD55_TX : ST_POWER;
            ST_CMD55_RX:
                judged_st = (resp_word.r1.status == R1_IDLE) ? ST_ACMD41_TX : ST_CMD55_TX;
            default:  // acmd41, busy card goes round again
                judged_st = (resp_word.r1.status == R1_READY) ? ST_DONE : ST_CMD55_TX;
        endcase
    end

    // ********************
    // state register
    // ********************
    always_ff @(posedge div_clk) begin
        if (!rst_n) begin
            state     <= ST_POWER;
            launched  <= 1'b0;
            cmd_start <= 1'b0;
            sd_cs     <= 1'b1;
        end else begin
            cmd_start <= 1'b0;
            case (state)
                ST_POWER: begin
                    sd_cs    <= 1'b1;
                    launched <= 1'b0;
                    if (pwr_ok)
                        state <= ST_CMD0_TX;
                end
                ST_CMD0_TX, ST_CMD8_TX, ST_CMD55_TX, ST_ACMD41_TX: begin
                    if (!launched) begin
                        cmd_start <= 1'b1;
                        sd_cs     <= 1'b0;  // select together with the start strobe
                        launched  <= 1'b1;
                    end else if (cmd_done) begin
                        launched <= 1'b0;
                        state    <= state + 1'b1;  // into the wait half
                    end
                end
                ST_CMD0_RX, ST_CMD8_RX, ST_CMD55_RX, ST_ACMD41_RX: begin
                    if (resp_valid) begin
                        sd_cs <= 1'b1;
                        state <= judged_st;
                    end else if (time_out) begin
                        sd_cs <= 1'b1;  // no answer, start over
                        state <= ST_POWER;
                    end
                end
                ST_DONE:
                    sd_cs <= 1'b1;
                default:
                    state <= ST_POWER;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/sd_wait_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sd_wait_timer #(
    parameter int unsigned POWER_ON_NUM  = 5000,
    parameter int unsigned OVER_TIME_NUM = 25000
) (
    input  logic div_clk,
    input  logic rst_n,
    input  logic pwr_wait,
    input  logic resp_wait,
    output logic pwr_ok,
    output logic time_out
);
    import sd_spi_pkg::*;

    localparam logic [PWR_CNT_W-1:0] PWR_END  = PWR_CNT_W'(POWER_ON_NUM);
    localparam logic [PWR_CNT_W-1:0] PWR_LAST = PWR_CNT_W'(POWER_ON_NUM - 1);
    localparam logic [TMO_CNT_W-1:0] TMO_LAST = TMO_CNT_W'(OVER_TIME_NUM - 1);

    logic [PWR_CNT_W-1:0] pwr_cnt;
    logic [TMO_CNT_W-1:0] tmo_cnt;

    // power stability count, stops at its end value
    always_ff @(posedge div_clk) begin
        if (!rst_n || !pwr_wait) begin
            pwr_cnt <= '0;
            pwr_ok  <= 1'b0;
        end else begin
            if (pwr_cnt != PWR_END)
                pwr_cnt <= pwr_cnt + 1'b1;
            pwr_ok <= (pwr_cnt == PWR_LAST);  // single pulse
        end
    end

    // response timeout, wraps so a long wait fires again
    always_ff @(posedge div_clk) begin
        if (!rst_n || !resp_wait) begin
            tmo_cnt  <= '0;
            time_out <= 1'b0;
        end else if (tmo_cnt == TMO_LAST) begin
            tmo_cnt  <= '0;
            time_out <= 1'b1;
        end else begin
            tmo_cnt  <= tmo_cnt + 1'b1;
            time_out <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/sd_spi_pkg.sv
`default_nettype none

package sd_spi_pkg;

    // ********************
    // widths
    // ********************
    localparam int FRAME_W   = 48;  // command frame and response width
    localparam int PWR_CNT_W = 16;
    localparam int TMO_CNT_W = 16;

    // ********************
    // command frames, crc included
    // ********************
    // index, argument, crc7 with end bit
    localparam logic [FRAME_W-1:0] CMD0_FRAME   = {8'h40, 32'h0000_0000, 8'h95};
    localparam logic [FRAME_W-1:0] CMD8_FRAME   = {8'h48, 32'h0000_01aa, 8'h87};  // 2.7-3.6 V, aa check
    localparam logic [FRAME_W-1:0] CMD55_FRAME  = {8'h77, 32'h0000_0000, 8'hff};
    localparam logic [FRAME_W-1:0] ACMD41_FRAME = {8'h69, 32'h4000_0000, 8'hff};  // hcs set

    typedef enum logic [1:0] {
        CMD0   = 2'd0,
        CMD8   = 2'd1,
        CMD55  = 2'd2,
        ACMD41 = 2'd3
    } cmd_sel_t;

    // ********************
    // response views
    // ********************
    typedef struct packed {
        logic [7:0]  status;
        logic [39:0] fill;      // idle-high padding after the r1 byte
    } r1_view_t;

    typedef struct packed {
        logic [7:0]  status;
        logic [19:0] upper;
        logic [3:0]  volt;      // bits 19:16 of the word
        logic [15:0] echo_crc;
    } r7_view_t;

    typedef union packed {
        r1_view_t r1;
        r7_view_t r7;
    } sd_resp_u;

    localparam logic [7:0] R1_IDLE  = 8'h01;
    localparam logic [7:0] R1_READY = 8'h00;
    localparam logic [3:0] VOLT_OK  = 4'b0001;

    // sequencer states, each wait half directly follows its send half
    localparam int SEQ_ST_W = 4;
    localparam logic [SEQ_ST_W-1:0] ST_POWER     = 4'd0;
    localparam logic [SEQ_ST_W-1:0] ST_CMD0_TX   = 4'd1;
    localparam logic [SEQ_ST_W-1:0] ST_CMD0_RX   = 4'd2;
    localparam logic [SEQ_ST_W-1:0] ST_CMD8_TX   = 4'd3;
    localparam logic [SEQ_ST_W-1:0] ST_CMD8_RX   = 4'd4;
    localparam logic [SEQ_ST_W-1:0] ST_CMD55_TX  = 4'd5;
    localparam logic [SEQ_ST_W-1:0] ST_CMD55_RX  = 4'd6;
    localparam logic [SEQ_ST_W-1:0] ST_ACMD41_TX = 4'd7;
    localparam logic [SEQ_ST_W-1:0] ST_ACMD41_RX = 4'd8;
    localparam logic [SEQ_ST_W-1:0] ST_DONE      = 4'd9;

endpackage

`default_nettype wire
